// ==== Makefile ====
TOP = tb_stream_alu

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP) +verilator+error+limit+1000); \
	echo "$$out"; \
	echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

// ==== alu_execute.sv ====
`timescale 1ns/1ps

// Execute stage. All three units work on every item and the class from
// decode picks the one that is registered
module alu_execute
  import alu_pkg::*;
#(
  parameter int data_width = 16,
  parameter int tag_width  = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  dec_valid,
  output logic                  dec_ready,
  input  alu_class_t            dec_class,
  input  logic                  dec_sub,
  input  logic_sel_t            dec_logic_sel,
  input  logic                  dec_shift_left,
  input  shamt_t                dec_shamt,
  input  logic [data_width-1:0] dec_a,
  input  logic [data_width-1:0] dec_b,
  input  logic [tag_width-1:0]  dec_tag,
  input  logic                  dec_illegal,

  output logic                  exe_valid,
  input  logic                  exe_ready,
  output logic [data_width-1:0] exe_result,
  output logic                  exe_carry,
  output logic                  exe_illegal,
  output logic [tag_width-1:0]  exe_tag
);

  logic                  valid_q;

  // One extra bit on the sum holds the carry-out
  logic [data_width:0]   sum;
  logic [data_width-1:0] logic_res;
  logic [data_width-1:0] shift_res;
  logic [data_width-1:0] result_d;
  logic                  carry_d;

  // --------------------------------------------------
  // Functional units
  // --------------------------------------------------

  // For sub, b arrives inverted and dec_sub adds the one, so the carry-out
  // is high exactly when there is no borrow (a >= b)
  assign sum = {1'b0, dec_a} + {1'b0, dec_b} + {{data_width{1'b0}}, dec_sub};

  always_comb begin
    case (dec_logic_sel)
      sel_and: logic_res = dec_a & dec_b;
      sel_or:  logic_res = dec_a | dec_b;
      sel_xor: logic_res = dec_a ^ dec_b;
      default: logic_res = '0;
    endcase
  end

  // Logical shifts, zeros come in from either side
  assign shift_res = dec_shift_left ? (dec_a << dec_shamt) : (dec_a >> dec_shamt);

  // Carry is only defined for arithmetic; other classes report zero
  always_comb begin
    result_d = '0;
    carry_d  = 1'b0;
    case (dec_class)
      class_arith: begin
        result_d = sum[data_width-1:0];
        carry_d  = sum[data_width];
      end
      class_logic: result_d = logic_res;
      class_shift: result_d = shift_res;
      default: begin
        result_d = '0;
        carry_d  = 1'b0;
      end
    endcase
  end

  // --------------------------------------------------
  // Stage register
  // --------------------------------------------------

  assign dec_ready = !valid_q || exe_ready;
  assign exe_valid = valid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (dec_ready) begin
      valid_q <= dec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (dec_valid && dec_ready) begin
      exe_result  <= result_d;
      exe_carry   <= carry_d;
      exe_illegal <= dec_illegal;
      exe_tag     <= dec_tag;
    end
  end

endmodule : alu_execute

// ==== alu_pkg.sv ====
package alu_pkg;

  // --------------------------------------------------
  // Opcodes
  // --------------------------------------------------

  // Command opcode as carried on the input port
  typedef logic [2:0] op_t;

  localparam op_t op_add = 3'd0;
  localparam op_t op_sub = 3'd1;
  localparam op_t op_and = 3'd2;
  localparam op_t op_or  = 3'd3;
  localparam op_t op_xor = 3'd4;
  localparam op_t op_shl = 3'd5;
  localparam op_t op_shr = 3'd6;
  // Code 7 has no operation assigned and decodes as illegal

  // --------------------------------------------------
  // Decode to execute controls
  // --------------------------------------------------

  // Picks which functional unit drives the execute result
  typedef logic [1:0] alu_class_t;

  localparam alu_class_t class_arith = 2'd0;
  localparam alu_class_t class_logic = 2'd1;
  localparam alu_class_t class_shift = 2'd2;
  // No unit selected, result and carry are forced to zero
  localparam alu_class_t class_none  = 2'd3;

  // Bitwise operation inside the logic unit
  typedef logic [1:0] logic_sel_t;

  localparam logic_sel_t sel_and = 2'd0;
  localparam logic_sel_t sel_or  = 2'd1;
  localparam logic_sel_t sel_xor = 2'd2;

  // Shift distance, taken from the low bits of operand b
  typedef logic [3:0] shamt_t;

endpackage : alu_pkg

// ==== cmd_decode.sv ====
`timescale 1ns/1ps

// Decode stage of the ALU pipeline. Turns the opcode into unit controls
// and registers them together with the operands and the tag
module cmd_decode
  import alu_pkg::*;
#(
  parameter int data_width = 16,
  parameter int tag_width  = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  in_valid,
  output logic                  in_ready,
  input  op_t                   in_op,
  input  logic [data_width-1:0] in_a,
  input  logic [data_width-1:0] in_b,
  input  logic [tag_width-1:0]  in_tag,

  output logic                  dec_valid,
  input  logic                  dec_ready,
  output alu_class_t            dec_class,
  output logic                  dec_sub,
  output logic_sel_t            dec_logic_sel,
  output logic                  dec_shift_left,
  output shamt_t                dec_shamt,
  output logic [data_width-1:0] dec_a,
  output logic [data_width-1:0] dec_b,
  output logic [tag_width-1:0]  dec_tag,
  output logic                  dec_illegal
);

  // --------------------------------------------------
  // Opcode decode
  // --------------------------------------------------

  logic       valid_q;
  alu_class_t class_d;
  logic       sub_d;
  logic_sel_t sel_d;
  logic       left_d;
  logic       illegal_d;

  // Every control defaults to its inactive value, each opcode sets only
  // what it needs
  always_comb begin
    class_d   = class_none;
    sub_d     = 1'b0;
    sel_d     = sel_and;
    left_d    = 1'b0;
    illegal_d = 1'b0;
    case (in_op)
      op_add: class_d = class_arith;
      op_sub: begin
        class_d = class_arith;
        sub_d   = 1'b1;
      end
      op_and: class_d = class_logic;
      op_or: begin
        class_d = class_logic;
        sel_d   = sel_or;
      end
      op_xor: begin
        class_d = class_logic;
        sel_d   = sel_xor;
      end
      op_shl: begin
        class_d = class_shift;
        left_d  = 1'b1;
      end
      op_shr: class_d = class_shift;
      default: illegal_d = 1'b1;
    endcase
  end

  // --------------------------------------------------
  // Stage register
  // --------------------------------------------------

  // Stage takes a new item when empty or when its item leaves this cycle
  assign in_ready  = !valid_q || dec_ready;
  assign dec_valid = valid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (in_ready) begin
      valid_q <= in_valid;
    end
  end

  // Subtraction is a + ~b + 1, so b is stored inverted and dec_sub is
  // the carry-in of the adder
  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      dec_class      <= class_d;
      dec_sub        <= sub_d;
      dec_logic_sel  <= sel_d;
      dec_shift_left <= left_d;
      dec_shamt      <= in_b[$bits(shamt_t)-1:0];
      dec_a          <= in_a;
      dec_b          <= sub_d ? ~in_b : in_b;
      dec_tag        <= in_tag;
      dec_illegal    <= illegal_d;
    end
  end

endmodule : cmd_decode

// ==== flow_reg_rev.sv ====
`timescale 1ns/1ps

// One-entry reverse flow register used as the input skid of the ALU.
// The ready toward the sender is a flop, so the long combinational ready
// chain of the pipeline stops here
module flow_reg_rev #(
  parameter int bit_width = 1
) (
  input  logic                 clk,
  input  logic                 rst_n,

  output logic                 push_ready,
  input  logic                 push_valid,
  input  logic [bit_width-1:0] push_data,

  input  logic                 pop_ready,
  output logic                 pop_valid,
  output logic [bit_width-1:0] pop_data
);

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------

  // Held item, only meaningful while push_ready is low
  logic [bit_width-1:0] reg_data;

  // A push that the pop side cannot take in the same cycle
  logic capture;

  assign capture = push_ready && push_valid && !pop_ready;

  // --------------------------------------------------
  // Pop side
  // --------------------------------------------------

  // Empty register passes the push side straight through (cut-through),
  // full register presents the held item until it is popped
  assign pop_valid = !push_ready || push_valid;
  assign pop_data  = push_ready ? push_data : reg_data;

  // --------------------------------------------------
  // Push side
  // --------------------------------------------------

  // push_ready doubles as the empty flag. It drops one cycle after a
  // stalled pop leaves an item behind and returns one cycle after the pop
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      push_ready <= 1'b1;
    end else begin
      push_ready <= pop_ready || !pop_valid;
    end
  end

  // Only a push into the empty register is captured, so a sender that
  // holds its next item during a stall cannot overwrite the stored one
  always_ff @(posedge clk) begin
    if (capture) begin
      reg_data <= push_data;
    end
  end

endmodule : flow_reg_rev

// ==== result_format.sv ====
`timescale 1ns/1ps

// Result stage. Adds the zero flag and holds the full response on the
// output port until the receiver takes it
module result_format #(
  parameter int data_width = 16,
  parameter int tag_width  = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  exe_valid,
  output logic                  exe_ready,
  input  logic [data_width-1:0] exe_result,
  input  logic                  exe_carry,
  input  logic                  exe_illegal,
  input  logic [tag_width-1:0]  exe_tag,

  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [data_width-1:0] out_result,
  output logic [tag_width-1:0]  out_tag,
  output logic                  out_zero,
  output logic                  out_carry,
  output logic                  out_illegal
);

  logic valid_q;
  logic zero_d;

  // --------------------------------------------------
  // Flags
  // --------------------------------------------------

  // An illegal command reaches here with a zero result, so it also
  // reports zero set
  assign zero_d = (exe_result == '0);

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------

  // While out_ready is low and an item is held, exe_ready stays low and
  // nothing below is loaded, so the response is stable
  assign exe_ready = !valid_q || out_ready;
  assign out_valid = valid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (exe_ready) begin
      valid_q <= exe_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (exe_valid && exe_ready) begin
      out_result  <= exe_result;
      out_tag     <= exe_tag;
      out_zero    <= zero_d;
      out_carry   <= exe_carry;
      out_illegal <= exe_illegal;
    end
  end

endmodule : result_format

// ==== src.f ====
alu_pkg.sv
flow_reg_rev.sv
cmd_decode.sv
alu_execute.sv
result_format.sv
stream_alu_top.sv
stream_alu_asserts.sv
tb_stream_alu.sv

// ==== stream_alu_asserts.sv ====
`timescale 1ns/1ps

// Handshake and timing properties of the streaming ALU, bound into
// stream_alu_top so that internal stage valids are visible
module stream_alu_asserts
  import alu_pkg::*;
#(
  parameter int data_width = 16,
  parameter int tag_width  = 4
) (
  input logic                                           clk,
  input logic                                           rst_n,
  input logic                                           in_valid,
  input logic                                           in_ready,
  input op_t                                            in_op,
  input logic [data_width-1:0]                          in_a,
  input logic [data_width-1:0]                          in_b,
  input logic [tag_width-1:0]                           in_tag,
  input logic                                           pop_valid,
  input logic                                           pop_ready,
  input logic [$bits(op_t)+2*data_width+tag_width-1:0] pop_data,
  input logic                                           dec_valid,
  input logic                                           exe_valid,
  input logic                                           out_valid,
  input logic                                           out_ready,
  input logic [data_width-1:0]                          out_result,
  input logic [tag_width-1:0]                           out_tag,
  input logic                                           out_zero,
  input logic                                           out_carry,
  input logic                                           out_illegal
);

  // Failed properties so far, read by the testbench
  int   fail_count = 0;
  logic take;

  // Accepted on the input while the output side is moving
  assign take = in_valid && in_ready && out_ready;

  // --------------------------------------------------
  // Handshake stability
  // --------------------------------------------------

  a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
    in_valid && !in_ready |=> in_valid && $stable({in_op, in_a, in_b, in_tag}))
  else begin
    fail_count++;
    $error("input command changed while in_ready was low");
  end

  // Skid output must keep a stalled item, whether bypassed or captured
  a_skid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    pop_valid && !pop_ready |=> pop_valid && $stable(pop_data))
  else begin
    fail_count++;
    $error("skid register output changed while stalled");
  end

  a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid && !out_ready |=> out_valid &&
      $stable({out_result, out_tag, out_zero, out_carry, out_illegal}))
  else begin
    fail_count++;
    $error("response changed while out_ready was low");
  end

  a_out_known: assert property (@(posedge clk) disable iff (!rst_n)
    out_valid |-> !$isunknown({out_result, out_tag, out_zero, out_carry, out_illegal}))
  else begin
    fail_count++;
    $error("unknown value on the output port while out_valid was high");
  end

  // --------------------------------------------------
  // Reset and timing
  // --------------------------------------------------

  a_reset_state: assert property (@(posedge clk)
    $rose(rst_n) |-> in_ready && !pop_valid && !dec_valid && !exe_valid && !out_valid)
  else begin
    fail_count++;
    $error("pipeline not empty or in_ready low when reset was released");
  end

  // Three sampled edges from acceptance to out_valid when nothing stalls
  a_latency: assert property (@(posedge clk) disable iff (!rst_n)
    $past(take, 3) && $past(out_ready, 2) && $past(out_ready, 1)
      |-> out_valid && out_tag == $past(in_tag, 3))
  else begin
    fail_count++;
    $error("response missing or wrong tag three edges after acceptance");
  end

  // in_ready may only drop when the skid and all three stages are full
  a_ready_fall: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(in_ready) |-> $past(pop_valid && dec_valid && exe_valid && out_valid && !out_ready))
  else begin
    fail_count++;
    $error("in_ready fell while the pipeline still had room");
  end

endmodule : stream_alu_asserts

bind stream_alu_top stream_alu_asserts #(
  .data_width (data_width),
  .tag_width  (tag_width)
) asserts_i (
  .clk         (clk),
  .rst_n       (rst_n),
  .in_valid    (in_valid),
  .in_ready    (in_ready),
  .in_op       (in_op),
  .in_a        (in_a),
  .in_b        (in_b),
  .in_tag      (in_tag),
  .pop_valid   (pop_valid),
  .pop_ready   (pop_ready),
  .pop_data    (pop_data),
  .dec_valid   (dec_valid),
  .exe_valid   (exe_valid),
  .out_valid   (out_valid),
  .out_ready   (out_ready),
  .out_result  (out_result),
  .out_tag     (out_tag),
  .out_zero    (out_zero),
  .out_carry   (out_carry),
  .out_illegal (out_illegal)
);

// ==== stream_alu_top.sv ====
`timescale 1ns/1ps

// Streaming ALU. Input skid, then decode, execute and result stages.
// With no back-pressure, a command accepted on edge N goes through the
// skid in the same cycle, is captured by decode on edge N, and has
// out_valid high after edge N+2
module stream_alu_top
  import alu_pkg::*;
#(
  parameter int data_width = 16,
  parameter int tag_width  = 4
) (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  in_valid,
  output logic                  in_ready,
  input  op_t                   in_op,
  input  logic [data_width-1:0] in_a,
  input  logic [data_width-1:0] in_b,
  input  logic [tag_width-1:0]  in_tag,

  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [data_width-1:0] out_result,
  output logic [tag_width-1:0]  out_tag,
  output logic                  out_zero,
  output logic                  out_carry,
  output logic                  out_illegal
);

  // Packed command is {op, a, b, tag}, op in the top bits
  localparam int cmd_width = $bits(op_t) + 2 * data_width + tag_width;

  // --------------------------------------------------
  // Interstage wires
  // --------------------------------------------------

  logic [cmd_width-1:0]  push_data;
  logic [cmd_width-1:0]  pop_data;
  logic                  pop_valid;
  logic                  pop_ready;

  op_t                   skid_op;
  logic [data_width-1:0] skid_a;
  logic [data_width-1:0] skid_b;
  logic [tag_width-1:0]  skid_tag;

  logic                  dec_valid;
  logic                  dec_ready;
  alu_class_t            dec_class;
  logic                  dec_sub;
  logic_sel_t            dec_logic_sel;
  logic                  dec_shift_left;
  shamt_t                dec_shamt;
  logic [data_width-1:0] dec_a;
  logic [data_width-1:0] dec_b;
  logic [tag_width-1:0]  dec_tag;
  logic                  dec_illegal;

  logic                  exe_valid;
  logic                  exe_ready;
  logic [data_width-1:0] exe_result;
  logic                  exe_carry;
  logic                  exe_illegal;
  logic [tag_width-1:0]  exe_tag;

  assign push_data = {in_op, in_a, in_b, in_tag};
  assign {skid_op, skid_a, skid_b, skid_tag} = pop_data;

  // --------------------------------------------------
  // Pipeline
  // --------------------------------------------------

  flow_reg_rev #(
    .bit_width (cmd_width)
  ) flow_reg_rev_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .push_ready (in_ready),
    .push_valid (in_valid),
    .push_data  (push_data),
    .pop_ready  (pop_ready),
    .pop_valid  (pop_valid),
    .pop_data   (pop_data)
  );

  cmd_decode #(
    .data_width (data_width),
    .tag_width  (tag_width)
  ) cmd_decode_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid       (pop_valid),
    .in_ready       (pop_ready),
    .in_op          (skid_op),
    .in_a           (skid_a),
    .in_b           (skid_b),
    .in_tag         (skid_tag),
    .dec_valid      (dec_valid),
    .dec_ready      (dec_ready),
    .dec_class      (dec_class),
    .dec_sub        (dec_sub),
    .dec_logic_sel  (dec_logic_sel),
    .dec_shift_left (dec_shift_left),
    .dec_shamt      (dec_shamt),
    .dec_a          (dec_a),
    .dec_b          (dec_b),
    .dec_tag        (dec_tag),
    .dec_illegal    (dec_illegal)
  );

  alu_execute #(
    .data_width (data_width),
    .tag_width  (tag_width)
  ) alu_execute_i (
    .clk            (clk),
    .rst_n          (rst_n),
    .dec_valid      (dec_valid),
    .dec_ready      (dec_ready),
    .dec_class      (dec_class),
    .dec_sub        (dec_sub),
    .dec_logic_sel  (dec_logic_sel),
    .dec_shift_left (dec_shift_left),
    .dec_shamt      (dec_shamt),
    .dec_a          (dec_a),
    .dec_b          (dec_b),
    .dec_tag        (dec_tag),
    .dec_illegal    (dec_illegal),
    .exe_valid      (exe_valid),
    .exe_ready      (exe_ready),
    .exe_result     (exe_result),
    .exe_carry      (exe_carry),
    .exe_illegal    (exe_illegal),
    .exe_tag        (exe_tag)
  );

  result_format #(
    .data_width (data_width),
    .tag_width  (tag_width)
  ) result_format_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .exe_valid   (exe_valid),
    .exe_ready   (exe_ready),
    .exe_result  (exe_result),
    .exe_carry   (exe_carry),
    .exe_illegal (exe_illegal),
    .exe_tag     (exe_tag),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_result  (out_result),
    .out_tag     (out_tag),
    .out_zero    (out_zero),
    .out_carry   (out_carry),
    .out_illegal (out_illegal)
  );

endmodule : stream_alu_top

// ==== tb_stream_alu.sv ====
`timescale 1ns/1ps

// Testbench for stream_alu_top. Drives commands through the input port,
// keeps the expected responses in a queue and checks every output handshake
// against the head of that queue
module tb_stream_alu
  import alu_pkg::*;
();

  localparam int data_width = 16;
  localparam int tag_width  = 4;
  localparam int clk_period = 10;

  // Commands per test; the watchdog budget follows from their sum
  localparam int n_arith         = 24;
  localparam int n_logic         = 20;
  localparam int n_illegal       = 5;
  localparam int n_burst         = 16;
  localparam int n_bp            = 40;
  localparam int n_total         = n_arith + n_logic + n_illegal + n_burst + n_bp;
  localparam int watchdog_cycles = 200 * n_total;

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid;
  logic                  in_ready;
  op_t                   in_op;
  logic [data_width-1:0] in_a;
  logic [data_width-1:0] in_b;
  logic [tag_width-1:0]  in_tag;
  logic                  out_valid;
  logic                  out_ready;
  logic [data_width-1:0] out_result;
  logic [tag_width-1:0]  out_tag;
  logic                  out_zero;
  logic                  out_carry;
  logic                  out_illegal;

  int                    seed;
  int                    ready_seed;
  logic [31:0]           rnd;
  logic [31:0]           ready_rnd;
  logic                  bp_mode;
  logic [tag_width-1:0]  tag_ctr;

  // Main process counts its own errors, the monitor keeps a separate count
  int errors;
  int mon_errors;
  int tests_run;
  int tests_failed;
  int err_mark;
  int mon_mark;
  int asrt_mark;

  // Expected responses in command order
  logic [data_width-1:0] exp_result[$];
  logic [tag_width-1:0]  exp_tag[$];
  logic                  exp_zero[$];
  logic                  exp_carry[$];
  logic                  exp_illegal[$];

  stream_alu_top #(
    .data_width (data_width),
    .tag_width  (tag_width)
  ) stream_alu_top_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_ready    (in_ready),
    .in_op       (in_op),
    .in_a        (in_a),
    .in_b        (in_b),
    .in_tag      (in_tag),
    .out_valid   (out_valid),
    .out_ready   (out_ready),
    .out_result  (out_result),
    .out_tag     (out_tag),
    .out_zero    (out_zero),
    .out_carry   (out_carry),
    .out_illegal (out_illegal)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  // Expected response from the opcode rules; sub carry means a >= b
  task automatic expect_cmd(input op_t op, input logic [data_width-1:0] a,
                            input logic [data_width-1:0] b,
                            input logic [tag_width-1:0] tag);
    logic [data_width:0]   sum;
    logic [data_width-1:0] res;
    logic                  carry;
    logic                  illegal;
    sum     = '0;
    res     = '0;
    carry   = 1'b0;
    illegal = 1'b0;
    case (op)
      op_add: begin
        sum   = {1'b0, a} + {1'b0, b};
        res   = sum[data_width-1:0];
        carry = sum[data_width];
      end
      op_sub: begin
        res   = a - b;
        carry = (a >= b);
      end
      op_and: res = a & b;
      op_or:  res = a | b;
      op_xor: res = a ^ b;
      op_shl: res = a << b[3:0];
      op_shr: res = a >> b[3:0];
      default: illegal = 1'b1;
    endcase
    exp_result.push_back(res);
    exp_tag.push_back(tag);
    exp_zero.push_back(res == '0);
    exp_carry.push_back(carry);
    exp_illegal.push_back(illegal);
  endtask

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------

  function automatic logic [data_width-1:0] rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r[data_width-1:0];
  endfunction

  // Holds the command on the port until in_ready was high at an edge.
  // in_ready is a flop, so its value 1 ns after the edge holds until the next one
  task automatic send_cmd(input op_t op, input logic [data_width-1:0] a,
                          input logic [data_width-1:0] b, output int waits);
    logic done;
    in_valid = 1'b1;
    in_op    = op;
    in_a     = a;
    in_b     = b;
    in_tag   = tag_ctr;
    waits    = 0;
    done     = 1'b0;
    while (!done) begin
      done = in_ready;
      @(posedge clk);
      #1;
      if (!done) waits++;
    end
    expect_cmd(op, a, b, tag_ctr);
    tag_ctr++;
  endtask

  task automatic idle_cycles(input int n);
    in_valid = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic start_test();
    err_mark  = errors;
    mon_mark  = mon_errors;
    asrt_mark = stream_alu_top_i.asserts_i.fail_count;
  endtask

  // Waits until every expected response has been seen, then reports the test
  task automatic end_test(input string name);
    int cycles;
    int n;
    cycles   = 0;
    in_valid = 1'b0;
    while (exp_result.size() != 0 && cycles < 1000) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (exp_result.size() != 0) begin
      $display("%0t: %0d responses never arrived", $time, exp_result.size());
      errors++;
    end
    n = (errors - err_mark) + (mon_errors - mon_mark) +
        (stream_alu_top_i.asserts_i.fail_count - asrt_mark);
    tests_run++;
    if (n == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, n);
    end
  endtask

  // --------------------------------------------------
  // Output side
  // --------------------------------------------------

  // Random back-pressure in bp_mode, otherwise always ready
  always begin
    @(posedge clk);
    #1;
    ready_rnd = $random(ready_seed);
    out_ready = bp_mode ? ready_rnd[0] : 1'b1;
  end

  task automatic check_field(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
      mon_errors++;
    end
  endtask

  // Sampled mid-cycle; a handshake seen here completes on the next rising edge
  always @(negedge clk) begin
    if (rst_n && out_valid && out_ready) begin
      if (exp_result.size() == 0) begin
        $display("%0t: response with tag %0h arrived with no command pending",
                 $time, out_tag);
        mon_errors++;
      end else begin
        check_field("out_result", 32'(out_result), 32'(exp_result.pop_front()));
        check_field("out_tag", 32'(out_tag), 32'(exp_tag.pop_front()));
        check_field("out_zero", 32'(out_zero), 32'(exp_zero.pop_front()));
        check_field("out_carry", 32'(out_carry), 32'(exp_carry.pop_front()));
        check_field("out_illegal", 32'(out_illegal), 32'(exp_illegal.pop_front()));
      end
    end
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog expired after %0d cycles, the run did not finish", watchdog_cycles);
    $display("Some tests failed");
    $finish;
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    int stalls;
    int burst_stalls;
    int total_errors;
    seed         = 32'he0e4ad7c;
    ready_seed   = 32'he0e4ad7c;
    rst_n        = 1'b0;
    in_valid     = 1'b0;
    in_op        = op_add;
    in_a         = '0;
    in_b         = '0;
    in_tag       = '0;
    out_ready    = 1'b0;
    bp_mode      = 1'b0;
    tag_ctr      = '0;
    errors       = 0;
    mon_errors   = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;
    idle_cycles(2);

    // Corner cases first: equal operands, wrap to zero, borrow
    start_test();
    send_cmd(op_sub, 16'h1234, 16'h1234, stalls);
    send_cmd(op_add, 16'hffff, 16'h0001, stalls);
    send_cmd(op_sub, 16'h0000, 16'h0001, stalls);
    send_cmd(op_add, 16'h8000, 16'h7fff, stalls);
    for (int i = 0; i < n_arith - 4; i++) begin
      rnd = $random(seed);
      send_cmd(rnd[0] ? op_sub : op_add, rand_word(), rand_word(), stalls);
    end
    end_test("arith");

    // Shifts by the extreme distances, then random logic and shift ops
    start_test();
    send_cmd(op_shl, 16'h0003, 16'h00ff, stalls);
    send_cmd(op_shr, 16'h8001, 16'hfff0, stalls);
    for (int i = 0; i < n_logic - 2; i++) begin
      rnd = $random(seed);
      send_cmd(op_t'(32'd2 + rnd % 32'd5), rand_word(), rand_word(), stalls);
    end
    end_test("logic_shift");

    // Illegal commands sit between legal ones
    start_test();
    send_cmd(op_add, 16'h0101, 16'h0202, stalls);
    send_cmd(op_t'(3'd7), 16'hbeef, 16'h1234, stalls);
    send_cmd(op_sub, 16'h0010, 16'h0020, stalls);
    send_cmd(op_t'(3'd7), 16'h0000, 16'h0000, stalls);
    send_cmd(op_add, 16'h7777, 16'h1111, stalls);
    end_test("illegal");

    // With out_ready high no command may wait for in_ready
    start_test();
    burst_stalls = 0;
    for (int i = 0; i < n_burst; i++) begin
      rnd = $random(seed);
      send_cmd(op_t'(rnd % 32'd7), rand_word(), rand_word(), stalls);
      burst_stalls += stalls;
    end
    if (burst_stalls != 0) begin
      $display("%0t: burst stalled %0d cycles with out_ready high", $time, burst_stalls);
      errors++;
    end
    end_test("burst");

    // Random out_ready and random gaps on the input, all opcodes
    start_test();
    bp_mode = 1'b1;
    for (int i = 0; i < n_bp; i++) begin
      rnd = $random(seed);
      send_cmd(op_t'(rnd[2:0]), rand_word(), rand_word(), stalls);
      if (rnd[4:3] == 2'b00) idle_cycles(1);
    end
    end_test("backpressure");
    bp_mode = 1'b0;

    // The reset property is sampled before the first test opens, so the
    // overall count is part of the verdict too
    total_errors = errors + mon_errors + stream_alu_top_i.asserts_i.fail_count;
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
             total_errors);
    if (tests_failed == 0 && total_errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule : tb_stream_alu
